//--- rtl/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Data bus width in bits
`define LSU_DATA_W 32

// Byte address width on the bus
`define LSU_ADDR_W 32

// One enable per byte lane of the data bus
`define LSU_BE_W 4

// Granted but unanswered bus transactions allowed at once
`define LSU_MAX_OUTSTANDING 2

`endif

//--- rtl/lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // Access encodings
  ////////////////////////////////////////////////////////////

  // Access size, same coding as the funct3 low bits of loads/stores
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  // Address phase of the access being issued
  // Second phase only exists for word-crossing accesses
  typedef enum logic {
    PHASE_FIRST  = 1'b0,
    PHASE_SECOND = 1'b1
  } split_state_e;

  ////////////////////////////////////////////////////////////
  // Data path types
  ////////////////////////////////////////////////////////////

  // One bus word
  typedef logic [`LSU_DATA_W-1:0] data_t;

  // One enable per byte lane
  typedef logic [`LSU_BE_W-1:0] be_t;

  // Byte position inside a word
  typedef logic [1:0] offset_t;

endpackage

//--- rtl/lsu_wb_if.sv
`timescale 1ns/1ps

// Access context handed from the address side to the response side
interface lsu_wb_if;

  // Load the context registers in the response stage
  logic       update;
  // Access size, coded as lsu_size_e
  logic [1:0] size;
  logic       sign_ext;
  logic       we;
  // Byte offset of the original (unaligned) address
  logic [1:0] offset;
  // Cleared for the first half of a split access
  logic       last;

  // Sequencer side
  modport seq (
    output update, size, sign_ext, we, offset, last
  );

  // Read aligner side
  modport align (
    input update, size, sign_ext, we, offset, last
  );

endinterface

//--- rtl/lsu_req_gen.sv
`timescale 1ns/1ps

module lsu_req_gen (
  input  lsu_pkg::data_t    req_base_i,
  input  lsu_pkg::data_t    req_offset_i,
  input  lsu_pkg::lsu_size_e req_size_i,
  input  lsu_pkg::data_t    req_wdata_i,
  input  logic              second_i,
  output lsu_pkg::offset_t  addr_lsb_o,
  output lsu_pkg::data_t    bus_addr_o,
  output lsu_pkg::be_t      bus_be_o,
  output lsu_pkg::data_t    bus_wdata_o
);

  import lsu_pkg::*;

  data_t            addr_sum;
  offset_t          lsb;
  logic [2*$bits(data_t)-1:0] wdata_dbl;

  ////////////////////////////////////////////////////////////
  // Address
  ////////////////////////////////////////////////////////////

  // Second phase points at the following word
  assign addr_sum = req_base_i + req_offset_i + (second_i ? data_t'(4) : data_t'(0));
  assign lsb      = addr_sum[1:0];

  // Low bits are kept so the aligner still sees the original offset
  assign addr_lsb_o = lsb;

  // Second phase always starts at byte 0 of its word
  assign bus_addr_o = second_i ? {addr_sum[$bits(data_t)-1:2], 2'b00} : addr_sum;

  ////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    bus_be_o = '0;
    case (req_size_i)
      SIZE_BYTE:
      begin
        // One lane that never splits
        bus_be_o = be_t'(4'b0001 << lsb);
      end
      SIZE_HALF:
      begin
        // At offset 3 only the top lane stays in this word
        if (!second_i)
          bus_be_o = be_t'(4'b0011 << lsb);
        else
          bus_be_o = be_t'(4'b0001);  // upper byte of a halfword at offset 3
      end
      default:
      begin
        // Word access takes the upper lanes first and the low lanes in the next word
        if (!second_i)
          bus_be_o = be_t'(4'b1111 << lsb);
        else
          bus_be_o = be_t'(4'b1111 >> (3'd4 - {1'b0, lsb}));
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Write data
  ////////////////////////////////////////////////////////////

  // Rotate left by the byte offset
  // In the second phase the wrapped bytes land on the low lanes
  assign wdata_dbl   = {req_wdata_i, req_wdata_i} << {lsb, 3'b000};
  assign bus_wdata_o = wdata_dbl[2*$bits(data_t)-1 -: $bits(data_t)];

endmodule

//--- rtl/lsu_outstanding_cnt.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_outstanding_cnt (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       granted_i,
  input  logic       rvalid_i,
  output logic [1:0] count_o,
  output logic       can_issue_o
);

  logic [1:0] count_q;
  logic [1:0] count_d;

  // Up on grant, down on response, hold when both coincide
  always_comb
  begin
    count_d = count_q;
    unique case ({granted_i, rvalid_i})
      2'b10:   count_d = count_q + 2'd1;
      2'b01:   count_d = count_q - 2'd1;
      default: count_d = count_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count_q <= 2'd0;
    end
    else
    begin
      count_q <= count_d;
    end
  end

  assign count_o = count_q;

  // Responses are never issued without a grant, so the only limit is the top
  assign can_issue_o = (count_q < `LSU_MAX_OUTSTANDING);

endmodule

//--- rtl/lsu_split_fsm.sv
`timescale 1ns/1ps

module lsu_split_fsm (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid_i,
  input  logic                req_we_i,
  input  lsu_pkg::lsu_size_e  req_size_i,
  input  logic                req_sign_ext_i,
  input  lsu_pkg::offset_t    addr_lsb_i,
  input  logic                bus_gnt_i,
  input  logic                bus_rvalid_i,
  input  logic                can_issue_i,
  input  logic [1:0]          count_i,
  output logic                bus_req_o,
  output logic                req_ready_o,
  output logic                second_o,
  output logic                granted_o,
  lsu_wb_if.seq               ctx
);

  import lsu_pkg::*;

  split_state_e state_q;
  split_state_e state_d;
  logic         split_first;
  logic         phase_done;

  ////////////////////////////////////////////////////////////
  // Split detection
  ////////////////////////////////////////////////////////////

  // Only the first phase can start a split
  always_comb
  begin
    split_first = 1'b0;
    if (req_valid_i && (state_q == PHASE_FIRST))
    begin
      case (req_size_i)
        SIZE_WORD: split_first = (addr_lsb_i != 2'd0);
        SIZE_HALF: split_first = (addr_lsb_i == 2'd3);
        default:   split_first = 1'b0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Issue and completion
  ////////////////////////////////////////////////////////////

  assign bus_req_o = req_valid_i && can_issue_i;
  assign granted_o = bus_req_o && bus_gnt_i;

  // Address side and response side advance together
  // With one in flight the previous response must retire in the same cycle
  // At two in flight this phase was already granted, it waits for the older response
  always_comb
  begin
    phase_done = 1'b0;
    if (req_valid_i)
    begin
      case (count_i)
        2'd0:    phase_done = granted_o;
        2'd1:    phase_done = granted_o && bus_rvalid_i;
        default: phase_done = bus_rvalid_i;
      endcase
    end
  end

  // Held low through the first half of a split
  assign req_ready_o = phase_done && !split_first;

  ////////////////////////////////////////////////////////////
  // Phase state
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    if (phase_done)
      state_d = split_first ? PHASE_SECOND : PHASE_FIRST;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= PHASE_FIRST;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  assign second_o = (state_q == PHASE_SECOND);

  // Context for the response stage, loaded as each phase completes
  assign ctx.update   = phase_done;
  assign ctx.size     = req_size_i;
  assign ctx.sign_ext = req_sign_ext_i;
  assign ctx.we       = req_we_i;
  assign ctx.offset   = addr_lsb_i;
  assign ctx.last     = !split_first;

endmodule

//--- rtl/lsu_rdata_align.sv
`timescale 1ns/1ps

module lsu_rdata_align (
  input  logic           clk,
  input  logic           rst_n,
  lsu_wb_if.align        ctx,
  input  logic           bus_rvalid_i,
  input  lsu_pkg::data_t bus_rdata_i,
  input  logic           bus_err_i,
  output logic           wb_valid_o,
  output lsu_pkg::data_t wb_rdata_o,
  output logic           wb_err_o
);

  import lsu_pkg::*;

  lsu_size_e size_q;
  logic      sign_ext_q;
  logic      we_q;
  offset_t   offset_q;
  logic      last_q;
  logic      err_acc_q;
  data_t     hold_q;
  data_t     rd_shift;
  logic [2*$bits(data_t)-1:0] join_shift;

  ////////////////////////////////////////////////////////////
  // Context of the oldest outstanding phase
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      size_q     <= SIZE_WORD;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
      offset_q   <= 2'd0;
      last_q     <= 1'b0;
    end
    else if (ctx.update)
    begin
      size_q     <= lsu_size_e'(ctx.size);
      sign_ext_q <= ctx.sign_ext;
      we_q       <= ctx.we;
      offset_q   <= ctx.offset;
      last_q     <= ctx.last;
    end
  end

  // First-half error, cleared by every last response
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      err_acc_q <= 1'b0;
    else if (bus_rvalid_i)
      err_acc_q <= !last_q && bus_err_i;
  end

  // Low word of a split load
  always_ff @(posedge clk)
  begin
    if (bus_rvalid_i && !last_q && !we_q)
      hold_q <= bus_rdata_i;
  end

  ////////////////////////////////////////////////////////////
  // Alignment and extension
  ////////////////////////////////////////////////////////////

  assign rd_shift   = bus_rdata_i >> {offset_q, 3'b000};
  // New word on top, held word below, shifted down to the access start
  assign join_shift = {bus_rdata_i, hold_q} >> {offset_q, 3'b000};

  always_comb
  begin
    wb_rdata_o = '0;
    case (size_q)
      SIZE_BYTE:
        wb_rdata_o = {{24{sign_ext_q & rd_shift[7]}}, rd_shift[7:0]};
      SIZE_HALF:
      begin
        if (offset_q == 2'd3)
          wb_rdata_o = {{16{sign_ext_q & join_shift[15]}}, join_shift[15:0]};
        else
          wb_rdata_o = {{16{sign_ext_q & rd_shift[15]}}, rd_shift[15:0]};
      end
      default:
        wb_rdata_o = (offset_q == 2'd0) ? bus_rdata_i : join_shift[31:0];
    endcase
  end

  // One pulse per access, on the last response only
  assign wb_valid_o = bus_rvalid_i && last_q;
  assign wb_err_o   = wb_valid_o && (bus_err_i || err_acc_q);

endmodule

//--- rtl/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // Execute side
  input  logic                   req_valid_i,
  input  logic                   req_we_i,
  input  lsu_pkg::lsu_size_e     req_size_i,
  input  logic                   req_sign_ext_i,
  input  logic [`LSU_ADDR_W-1:0] req_base_i,
  input  logic [`LSU_ADDR_W-1:0] req_offset_i,
  input  lsu_pkg::data_t         req_wdata_i,
  output logic                   req_ready_o,
  // Data bus
  output logic                   bus_req_o,
  output logic [`LSU_ADDR_W-1:0] bus_addr_o,
  output logic                   bus_we_o,
  output lsu_pkg::be_t           bus_be_o,
  output lsu_pkg::data_t         bus_wdata_o,
  input  logic                   bus_gnt_i,
  input  logic                   bus_rvalid_i,
  input  lsu_pkg::data_t         bus_rdata_i,
  input  logic                   bus_err_i,
  // Write-back side
  output logic                   wb_valid_o,
  output lsu_pkg::data_t         wb_rdata_o,
  output logic                   wb_err_o,
  output logic                   busy_o
);

  import lsu_pkg::*;

  offset_t    addr_lsb;
  logic       second;
  logic       granted;
  logic       can_issue;
  logic       bus_req;
  logic [1:0] count;

  lsu_wb_if wb_ctx ();

  ////////////////////////////////////////////////////////////
  // Address side
  ////////////////////////////////////////////////////////////

  lsu_req_gen u_req_gen (
    .req_base_i   (req_base_i),
    .req_offset_i (req_offset_i),
    .req_size_i   (req_size_i),
    .req_wdata_i  (req_wdata_i),
    .second_i     (second),
    .addr_lsb_o   (addr_lsb),
    .bus_addr_o   (bus_addr_o),
    .bus_be_o     (bus_be_o),
    .bus_wdata_o  (bus_wdata_o)
  );

  lsu_outstanding_cnt u_cnt (
    .clk         (clk),
    .rst_n       (rst_n),
    .granted_i   (granted),
    .rvalid_i    (bus_rvalid_i),
    .count_o     (count),
    .can_issue_o (can_issue)
  );

  lsu_split_fsm u_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid_i),
    .req_we_i       (req_we_i),
    .req_size_i     (req_size_i),
    .req_sign_ext_i (req_sign_ext_i),
    .addr_lsb_i     (addr_lsb),
    .bus_gnt_i      (bus_gnt_i),
    .bus_rvalid_i   (bus_rvalid_i),
    .can_issue_i    (can_issue),
    .count_i        (count),
    .bus_req_o      (bus_req),
    .req_ready_o    (req_ready_o),
    .second_o       (second),
    .granted_o      (granted),
    .ctx            (wb_ctx.seq)
  );

  ////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////

  lsu_rdata_align u_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctx          (wb_ctx.align),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_rdata_i  (bus_rdata_i),
    .bus_err_i    (bus_err_i),
    .wb_valid_o   (wb_valid_o),
    .wb_rdata_o   (wb_rdata_o),
    .wb_err_o     (wb_err_o)
  );

  assign bus_req_o = bus_req;
  assign bus_we_o  = req_we_i;

  // Busy while anything is in flight or about to be issued
  assign busy_o = (count != 2'd0) || bus_req;

endmodule

//--- testbench/lsu_checker.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_checker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [1:0]              count_i,
  input  logic                    bus_req_i,
  input  logic                    bus_gnt_i,
  input  logic                    req_ready_i,
  input  lsu_pkg::split_state_e   state_i,
  input  lsu_pkg::lsu_size_e      size_i,
  input  lsu_pkg::offset_t        lsb_i
);

  import lsu_pkg::*;

  // Access reaches into the next word
  logic crossing;

  assign crossing = (size_i == SIZE_WORD && lsb_i != 2'd0) ||
                    (size_i == SIZE_HALF && lsb_i == 2'd3);

  // Outstanding count stays within the configured depth
  count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count_i <= `LSU_MAX_OUTSTANDING)
    else $error("outstanding count %0d above limit", count_i);

  // A request without grant stays up in the same phase at the same offset
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_i && !bus_gnt_i |=> bus_req_i && $stable(state_i) && $stable(lsb_i))
    else $error("bus request dropped or changed before its grant");

  // First half of a split never accepts the access
  no_early_ready: assert property (@(posedge clk) disable iff (!rst_n)
    req_ready_i |-> !(state_i == PHASE_FIRST && crossing))
    else $error("ready raised in the first phase of a split access");

endmodule

bind lsu_split_fsm lsu_checker u_checker (
  .clk           (clk),
  .rst_n         (rst_n),
  .count_i       (count_i),
  .bus_req_i     (bus_req_o),
  .bus_gnt_i     (bus_gnt_i),
  .req_ready_i   (req_ready_o),
  .state_i       (state_q),
  .size_i        (req_size_i),
  .lsb_i         (addr_lsb_i)
);

//--- testbench/lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_tb;

  import lsu_pkg::*;

  localparam int MEM_WORDS  = 64;
  localparam int STEP_LIMIT = 60;

  logic                   clk;
  logic                   rst_n;
  logic                   req_valid_i;
  logic                   req_we_i;
  lsu_size_e              req_size_i;
  logic                   req_sign_ext_i;
  logic [`LSU_ADDR_W-1:0] req_base_i;
  logic [`LSU_ADDR_W-1:0] req_offset_i;
  data_t                  req_wdata_i;
  logic                   req_ready_o;
  logic                   bus_req_o;
  logic [`LSU_ADDR_W-1:0] bus_addr_o;
  logic                   bus_we_o;
  be_t                    bus_be_o;
  data_t                  bus_wdata_o;
  logic                   bus_gnt_i;
  logic                   bus_rvalid_i;
  data_t                  bus_rdata_i;
  logic                   bus_err_i;
  logic                   wb_valid_o;
  data_t                  wb_rdata_o;
  logic                   wb_err_o;
  logic                   busy_o;

  // Memory model, one word per index
  data_t       mem [MEM_WORDS];
  logic [31:0] rng_state;
  int          cyc;
  int          n_checks;
  int          n_errors;
  int          n_timeouts;
  // Owed bus responses, oldest first
  data_t       rsp_data [$];
  logic        rsp_err [$];
  int          rsp_due [$];
  // Expected write-back per access, oldest first
  data_t       exp_data [$];
  logic        exp_err [$];
  logic        exp_load [$];
  // Grants of the access being issued
  int          n_grants;
  logic [31:0] grant_addr [2];
  be_t         grant_be [2];

  lsu_top dut0 (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Lanes touched in a two-word window; upper half goes to the next word
  function automatic be_t ref_be(lsu_size_e size, logic [1:0] lsb, logic second);
    int         n;
    logic [7:0] lanes;
    n = (size == SIZE_BYTE) ? 1 : ((size == SIZE_HALF) ? 2 : 4);
    lanes = ((8'd1 << n) - 8'd1) << lsb;
    return second ? lanes[7:4] : lanes[3:0];
  endfunction

  // Falling edge: grant stalls and the head response
  task automatic drive_bus();
    logic [31:0] r;
    r = next_rand();
    // Roughly one cycle in four without grant
    bus_gnt_i = (r[9:8] != 2'd0);
    if (rsp_due.size() > 0 && rsp_due[0] <= cyc)
    begin
      bus_rvalid_i = 1'b1;
      bus_rdata_i  = rsp_data[0];
      bus_err_i    = rsp_err[0];
    end
    else
    begin
      bus_rvalid_i = 1'b0;
      bus_rdata_i  = '0;
      bus_err_i    = 1'b0;
    end
  endtask

  task automatic check_writeback();
    n_checks++;
    if (exp_data.size() == 0)
    begin
      n_errors++;
      $display("Write-back pulse at %0t with no access waiting for it", $time);
    end
    else
    begin
      assert (wb_err_o == exp_err[0])
      else
      begin
        n_errors++;
        $display("CHECK FAILED at %0t: wb_err_o %0b, expected %0b", $time, wb_err_o,
                 exp_err[0]);
      end
      if (exp_load[0] && !exp_err[0])
      begin
        assert (wb_rdata_o == exp_data[0])
        else
        begin
          n_errors++;
          $display("CHECK FAILED at %0t: wb_rdata_o %h, expected %h", $time, wb_rdata_o,
                   exp_data[0]);
        end
      end
      exp_data.delete(0);
      exp_err.delete(0);
      exp_load.delete(0);
    end
  endtask

  // Outputs are settled here and hold until the rising edge
  task automatic sample_edge();
    logic [31:0] r;
    int          idx;
    if (bus_rvalid_i)
    begin
      rsp_data.delete(0);
      rsp_err.delete(0);
      rsp_due.delete(0);
    end
    if (bus_req_o && bus_gnt_i)
    begin
      if (n_grants < 2)
      begin
        grant_addr[n_grants] = bus_addr_o;
        grant_be[n_grants]   = bus_be_o;
      end
      n_grants++;
      r = next_rand();
      // Anything past the 64-word array is a bus error
      if (bus_addr_o >= 32'h100)
      begin
        rsp_data.push_back('0);
        rsp_err.push_back(1'b1);
      end
      else
      begin
        idx = int'(bus_addr_o[7:2]);
        rsp_data.push_back(mem[idx]);
        rsp_err.push_back(1'b0);
        for (int b = 0; b < 4; b++)
        begin
          if (bus_we_o && bus_be_o[b])
            mem[idx][8*b +: 8] = bus_wdata_o[8*b +: 8];
        end
      end
      // Response one to three cycles after its grant
      rsp_due.push_back(cyc + 1 + int'(r % 32'd3));
    end
    if (wb_valid_o)
      check_writeback();
    cyc++;
  endtask

  ////////////////////////////////////////////////////////////
  // Access sequencing
  ////////////////////////////////////////////////////////////

  // Entered right after a falling edge, returns before the accepting edge
  task automatic run_access(logic we, lsu_size_e size, logic sgn, logic [31:0] base,
                            logic [31:0] off, logic [31:0] wdata, logic [31:0] erd,
                            logic eer);
    logic [31:0] addr;
    logic        split;
    logic        done;
    int          steps;
    addr  = base + off;
    split = (size == SIZE_WORD && addr[1:0] != 2'd0) ||
            (size == SIZE_HALF && addr[1:0] == 2'd3);
    exp_data.push_back(erd);
    exp_err.push_back(eer);
    exp_load.push_back(!we);
    req_valid_i    = 1'b1;
    req_we_i       = we;
    req_size_i     = size;
    req_sign_ext_i = sgn;
    req_base_i     = base;
    req_offset_i   = off;
    req_wdata_i    = wdata;
    n_grants       = 0;
    grant_addr[0]  = '0;
    grant_addr[1]  = '0;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < STEP_LIMIT)
    begin
      if (steps > 0)
        @(negedge clk);
      drive_bus();
      #1;
      done = req_ready_o;
      sample_edge();
      steps++;
    end
    if (!done)
    begin
      n_timeouts++;
      $display("Timeout: access at %h was never accepted", addr);
    end
    else
    begin
      n_checks++;
      assert (n_grants == (split ? 2 : 1) && grant_addr[0] == addr)
      else
      begin
        n_errors++;
        $display("CHECK FAILED at %0t: %0d grants, first at %h, for access at %h", $time,
                 n_grants, grant_addr[0], addr);
      end
      assert (grant_be[0] == ref_be(size, addr[1:0], 1'b0))
      else
      begin
        n_errors++;
        $display("CHECK FAILED at %0t: byte enables %b at %h", $time, grant_be[0], addr);
      end
      if (split && n_grants == 2)
      begin
        assert (grant_addr[1] == (addr & ~32'h3) + 32'h4 &&
                grant_be[1] == ref_be(size, addr[1:0], 1'b1))
        else
        begin
          n_errors++;
          $display("CHECK FAILED at %0t: second half at %h with enables %b", $time,
                   grant_addr[1], grant_be[1]);
        end
      end
    end
  endtask

  // Idle request side until every response and write-back is seen
  task automatic drain_bus();
    int steps;
    steps = 0;
    while ((rsp_due.size() > 0 || exp_data.size() > 0) && steps < STEP_LIMIT)
    begin
      @(negedge clk);
      req_valid_i = 1'b0;
      drive_bus();
      #1;
      sample_edge();
      steps++;
    end
    if (steps >= STEP_LIMIT)
    begin
      n_timeouts++;
      $display("Timeout: responses or write-backs still missing after the last access");
    end
    @(negedge clk);
    req_valid_i = 1'b0;
    drive_bus();
    #1;
    n_checks++;
    assert (!busy_o)
    else
    begin
      n_errors++;
      $display("CHECK FAILED at %0t: busy_o still high with nothing in flight", $time);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    int          fd;
    int          code;
    string       line;
    logic [31:0] op;
    logic [31:0] sz;
    logic [31:0] sg;
    logic [31:0] base;
    logic [31:0] off;
    logic [31:0] wd;
    logic [31:0] rd;
    logic [31:0] er;
    rng_state      = 32'he354_c03a;
    rst_n          = 1'b0;
    req_valid_i    = 1'b0;
    req_we_i       = 1'b0;
    req_size_i     = SIZE_WORD;
    req_sign_ext_i = 1'b0;
    req_base_i     = '0;
    req_offset_i   = '0;
    req_wdata_i    = '0;
    bus_gnt_i      = 1'b0;
    bus_rvalid_i   = 1'b0;
    bus_rdata_i    = '0;
    bus_err_i      = 1'b0;
    cyc            = 0;
    n_checks       = 0;
    n_errors       = 0;
    n_timeouts     = 0;
    n_grants       = 0;
    // Every byte of a word holds its word index
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = 32'(i) * 32'h0101_0101;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    fd = $fopen("testbench/lsu_stim.txt", "r");
    if (fd == 0)
    begin
      n_errors++;
      $display("Cannot open testbench/lsu_stim.txt");
    end
    else
    begin
      while (!$feof(fd) && n_timeouts == 0)
      begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line[0] != "#")
        begin
          code = $sscanf(line, "%h %h %h %h %h %h %h %h", op, sz, sg, base, off, wd, rd, er);
          if (code == 8)
          begin
            @(negedge clk);
            run_access(op[0], lsu_size_e'(sz[1:0]), sg[0], base, off, wd, rd, er[0]);
          end
        end
      end
      $fclose(fd);
      if (n_timeouts == 0)
        drain_bus();
    end
    $display("%0d checks, %0d errors, %0d timeouts", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

//--- testbench/lsu_stim.txt
# op (0 load, 1 store), size (0 byte, 1 half, 2 word), sign, base, offset, wdata, rdata, err
# All fields hex; rdata is compared only for loads that expect no error
1 2 0 00000020 00000000 a1b2c3d4 00000000 0
0 2 0 00000020 00000000 00000000 a1b2c3d4 0
1 1 0 00000030 00000002 00009876 00000000 0
0 1 1 00000030 00000002 00000000 ffff9876 0
0 1 0 00000030 00000002 00000000 00009876 0
1 0 0 00000040 00000001 000000e5 00000000 0
0 0 1 00000040 00000001 00000000 ffffffe5 0
0 0 0 00000040 00000001 00000000 000000e5 0
0 0 1 00000010 00000003 00000000 00000004 0
0 2 0 00000020 00000002 00000000 0909a1b2 0
1 2 0 00000050 00000001 11223344 00000000 0
0 2 0 00000050 00000000 00000000 22334414 0
0 2 0 00000054 00000000 00000000 15151511 0
0 2 0 00000050 00000003 00000000 15151122 0
1 1 0 00000060 00000003 0000beef 00000000 0
0 1 1 00000060 00000003 00000000 ffffbeef 0
0 1 0 00000060 00000003 00000000 0000beef 0
0 2 0 00000100 00000000 00000000 00000000 1
1 2 0 00000100 00000004 55aa55aa 00000000 1
0 2 0 000000f0 0000000e 00000000 00000000 1
0 1 1 000000ff 00000000 00000000 00000000 1
0 2 0 00000104 fffffff8 00000000 3f3f3f3f 0
0 0 0 00000008 00000003 00000000 00000002 0

//--- tb.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_wb_if.sv
rtl/lsu_req_gen.sv
rtl/lsu_outstanding_cnt.sv
rtl/lsu_split_fsm.sv
rtl/lsu_rdata_align.sv
rtl/lsu_top.sv
testbench/lsu_checker.sv
testbench/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the LSU testbench with Verilator, run it and scan the log

verilator --binary --timing --assert -f tb.f --top-module lsu_tb -o lsu_sim \
  && ./obj_dir/lsu_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "tests failed" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; }
echo "Simulation PASSED"
